// ==== include/rom_macros.svh ====
`ifndef ROM_MACROS_SVH
`define ROM_MACROS_SVH

// sdram word address width, one word is 32 bits
`define ROM_SDRAM_AW 22

// requester ports on the arbiter: cpu and gfx
`define ROM_NPORTS 2

// axi4-lite register map, byte addresses
`define ROM_AXI_AW   8
`define ROM_REG_OFS0 8'h00 // port 0 sdram base offset
`define ROM_REG_OFS1 8'h04 // port 1 sdram base offset
`define ROM_REG_CNT0 8'h08 // port 0 completed fetches, read only
`define ROM_REG_CNT1 8'h0c // port 1 completed fetches, read only

`endif

// ==== hw/rom_pkg.sv ====
`include "rom_macros.svh"

package rom_pkg;

    // one 32-bit rom word as stored in sdram
    // the cpu port reads it as bytes, the gfx port as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;  // bytes[0] is bits 7:0
        logic [1:0][15:0] halves; // halves[0] is bits 15:0
    } rom_word_u;

    // read request towards sdram, also used for a cache miss
    typedef struct packed {
        logic                     valid; // held while the request is open
        logic [`ROM_SDRAM_AW-1:0] addr;  // word address
    } sdram_rd_req_t;

    // returned word, valid for exactly one cycle
    typedef struct packed {
        logic      valid;
        rom_word_u data;
    } rom_fill_t;

endpackage

// ==== hw/axil_pkg.sv ====
`include "rom_macros.svh"

package axil_pkg;

    // master to slave signals of one axi4-lite link, 32-bit data
    typedef struct packed {
        logic                   awvalid;
        logic [`ROM_AXI_AW-1:0] awaddr;
        logic                   wvalid;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [`ROM_AXI_AW-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== hw/rom_req_cache.sv ====
`timescale 1ns/1ps
`include "rom_macros.svh"

// two-word cache in front of one rom requester
// hits answer one cycle after addr_ok, misses go to the arbiter
module rom_req_cache #(
    parameter int DW = 8,  // requester data width, 8 or 16
    parameter int AW = 18  // requester address width in DW units
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [AW-1:0]          addr,
    input  logic                   addr_ok, // addr is valid, held until data_ok
    output rom_pkg::sdram_rd_req_t miss,
    input  rom_pkg::rom_fill_t     fill,
    output logic [DW-1:0]          dout,
    output logic                   data_ok  // dout valid this cycle
);

    localparam int SH = (DW == 8) ? 2 : 1; // lane select bits below the word address
    localparam int WW = AW - SH;           // word address width

    logic [WW-1:0]      waddr;        // word holding the requested lane
    logic [WW-1:0]      ent_addr [2];
    rom_pkg::rom_word_u ent_data [2];
    logic [1:0]         hit;
    logic               victim;       // entry overwritten by the next fill
    logic               init;         // nothing stored yet
    rom_pkg::rom_word_u word_mux;

    assign waddr  = addr[AW-1:SH];
    assign hit[0] = waddr == ent_addr[0];
    assign hit[1] = waddr == ent_addr[1];

    // init keeps a request open until the first word lands,
    // that prefill takes whatever addr holds
    always_comb begin
        miss.valid = init || (addr_ok && !(|hit));
        miss.addr  = `ROM_SDRAM_AW'(waddr); // zero extended word address
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init    <= 1'b1;
            victim  <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            // fill cycle counts as a hit, word is stored by the next cycle
            data_ok <= addr_ok && (fill.valid || (!init && |hit));
            if (fill.valid) begin
                init <= 1'b0;
                if (!init) begin
                    victim <= ~victim; // alternate entries after the prefill
                end
            end
        end
    end

    // first fill writes both entries so no stale tag can match
    always_ff @(posedge clk) begin
        if (fill.valid) begin
            if (init || !victim) begin
                ent_addr[0] <= waddr;
                ent_data[0] <= fill.data;
            end
            if (init || victim) begin
                ent_addr[1] <= waddr;
                ent_data[1] <= fill.data;
            end
        end
    end

    // fresh data bypasses the entries, saves a cycle on a miss
    always_comb begin
        if (fill.valid) begin
            word_mux = fill.data;
        end else if (hit[0]) begin
            word_mux = ent_data[0];
        end else begin
            word_mux = ent_data[1];
        end
    end

    generate
        if (DW == 8) begin : g_byte
            assign dout = word_mux.bytes[addr[1:0]];  // cpu byte lane
        end else begin : g_half
            assign dout = word_mux.halves[addr[0]];   // gfx halfword lane
        end
    endgenerate

    // no data can be reported before a word has been stored
    a_no_early_ok: assert property (@(posedge clk) disable iff (rst)
        init |-> !data_ok);

    // the arbiter only answers a port that is still asking
    a_fill_on_miss: assert property (@(posedge clk) disable iff (rst)
        fill.valid |-> miss.valid);

endmodule

// ==== hw/rom_sdram_arbiter.sv ====
`timescale 1ns/1ps
`include "rom_macros.svh"

// single sdram read channel shared by the cache ports
// one read in flight, round robin between ports that miss
module rom_sdram_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  rom_pkg::sdram_rd_req_t   miss [`ROM_NPORTS],
    output rom_pkg::rom_fill_t       fill [`ROM_NPORTS],
    input  logic [`ROM_SDRAM_AW-1:0] port_ofs [`ROM_NPORTS], // per port base, in words
    output logic [`ROM_NPORTS-1:0]   fetch_done,
    output rom_pkg::sdram_rd_req_t   sdram_req,
    input  rom_pkg::rom_fill_t       sdram_rsp
);

    localparam int NP = `ROM_NPORTS;
    localparam int PW = (NP > 1) ? $clog2(NP) : 1; // port index width

    logic                     busy;       // read in flight
    logic [PW-1:0]            gnt;        // owner of the read in flight
    logic [PW-1:0]            rr;         // port that wins the next tie
    logic [PW-1:0]            pick;
    logic [PW-1:0]            idx;
    logic                     found;
    logic [`ROM_SDRAM_AW-1:0] issue_addr; // offset added, for the picked port
    logic [`ROM_SDRAM_AW-1:0] req_addr;   // latched at grant

    // scan from rr upwards, first requesting port wins
    always_comb begin
        pick  = rr;
        found = 1'b0;
        idx   = rr;
        for (int i = 0; i < NP; i++) begin
            idx = PW'((int'(rr) + i) % NP);
            if (!found && miss[idx].valid) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    assign issue_addr = miss[pick].addr + port_ofs[pick];

    // request goes out in the grant cycle, then stays on the latched copy
    always_comb begin
        sdram_req.valid = busy || found;
        sdram_req.addr  = busy ? req_addr : issue_addr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            gnt  <= '0;
            rr   <= '0;
        end else if (!busy) begin
            if (found) begin
                busy <= 1'b1;
                gnt  <= pick;
                rr   <= (pick == PW'(NP - 1)) ? '0 : pick + 1'b1; // other port next
            end
        end else if (sdram_rsp.valid) begin
            busy <= 1'b0; // free again next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && found) begin
            req_addr <= issue_addr;
        end
    end

    // returned word goes to the owner only
    always_comb begin
        for (int i = 0; i < NP; i++) begin
            fill[i].valid = busy && sdram_rsp.valid && (gnt == PW'(i));
            fill[i].data  = sdram_rsp.data;
            fetch_done[i] = fill[i].valid;
        end
    end

    // sdram sees one steady address per read
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        sdram_req.valid && !sdram_rsp.valid |=> $stable(sdram_req.addr));

    a_one_fill: assert property (@(posedge clk) disable iff (rst)
        $onehot0(fetch_done));

endmodule

// ==== hw/rom_cfg_regs.sv ====
`timescale 1ns/1ps
`include "rom_macros.svh"

// axi4-lite registers: per port sdram offsets and fetch counters
module rom_cfg_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  axil_pkg::axil_req_t      axil_req,
    output axil_pkg::axil_rsp_t      axil_rsp,
    output logic [`ROM_SDRAM_AW-1:0] port_ofs [`ROM_NPORTS],
    input  logic [`ROM_NPORTS-1:0]   fetch_done // one pulse per completed fetch
);

    logic        wr_take;   // aw and w accepted together
    logic        rd_take;
    logic        wr_hit;    // write address is one of the four registers
    logic        bvalid;
    logic        rvalid;
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    logic [31:0] rdata;
    logic [31:0] fetch_cnt [`ROM_NPORTS]; // wraps

    // byte strobes applied on a zero extended copy of the offset
    function automatic logic [`ROM_SDRAM_AW-1:0] strb_merge(
        input logic [`ROM_SDRAM_AW-1:0] old_val,
        input logic [31:0]              wdata,
        input logic [3:0]               wstrb
    );
        logic [31:0] merged;
        merged = 32'(old_val);
        for (int i = 0; i < 4; i++) begin
            if (wstrb[i]) begin
                merged[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return merged[`ROM_SDRAM_AW-1:0];
    endfunction

    assign wr_take = axil_req.awvalid && axil_req.wvalid && !bvalid; // one write at a time
    assign rd_take = axil_req.arvalid && !rvalid;
    assign wr_hit  = axil_req.awaddr inside {`ROM_REG_OFS0, `ROM_REG_OFS1,
                                             `ROM_REG_CNT0, `ROM_REG_CNT1};

    always_comb begin
        axil_rsp.awready = wr_take;
        axil_rsp.wready  = wr_take;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = !rvalid;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            for (int i = 0; i < `ROM_NPORTS; i++) begin
                port_ofs[i]  <= '0;
                fetch_cnt[i] <= '0;
            end
        end else begin
            if (wr_take) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            // counter writes fall through, they still answer okay
            if (wr_take && axil_req.awaddr == `ROM_REG_OFS0) begin
                port_ofs[0] <= strb_merge(port_ofs[0], axil_req.wdata, axil_req.wstrb);
            end
            if (wr_take && axil_req.awaddr == `ROM_REG_OFS1) begin
                port_ofs[1] <= strb_merge(port_ofs[1], axil_req.wdata, axil_req.wstrb);
            end
            for (int i = 0; i < `ROM_NPORTS; i++) begin
                if (fetch_done[i]) begin
                    fetch_cnt[i] <= fetch_cnt[i] + 32'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            bresp <= wr_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_take) begin
            rvalid <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    // read data captured at address acceptance, held with rvalid
    always_ff @(posedge clk) begin
        if (rd_take) begin
            rresp <= axil_pkg::RESP_OKAY;
            case (axil_req.araddr)
                `ROM_REG_OFS0: rdata <= 32'(port_ofs[0]);
                `ROM_REG_OFS1: rdata <= 32'(port_ofs[1]);
                `ROM_REG_CNT0: rdata <= fetch_cnt[0];
                `ROM_REG_CNT1: rdata <= fetch_cnt[1];
                default: begin
                    rdata <= '0;
                    rresp <= axil_pkg::RESP_SLVERR; // unmapped
                end
            endcase
        end
    end

    // responses wait for the master
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid);

endmodule

// ==== hw/rom_subsys_top.sv ====
`timescale 1ns/1ps
`include "rom_macros.svh"

// rom access layer: cpu and gfx caches sharing one sdram read channel
module rom_subsys_top #(
    localparam int CPU_AW = 18, // cpu byte address
    localparam int GFX_AW = 17  // gfx halfword address
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [CPU_AW-1:0]      cpu_addr,
    input  logic                   cpu_addr_ok,
    output logic [7:0]             cpu_dout,
    output logic                   cpu_data_ok,
    input  logic [GFX_AW-1:0]      gfx_addr,
    input  logic                   gfx_addr_ok,
    output logic [15:0]            gfx_dout,
    output logic                   gfx_data_ok,
    output rom_pkg::sdram_rd_req_t sdram_req,
    input  rom_pkg::rom_fill_t     sdram_rsp,
    input  axil_pkg::axil_req_t    axil_req,
    output axil_pkg::axil_rsp_t    axil_rsp
);

    rom_pkg::sdram_rd_req_t   miss [`ROM_NPORTS];     // index 0 cpu, 1 gfx
    rom_pkg::rom_fill_t       fill [`ROM_NPORTS];
    logic [`ROM_SDRAM_AW-1:0] port_ofs [`ROM_NPORTS];
    logic [`ROM_NPORTS-1:0]   fetch_done;

    rom_req_cache #(.DW(8), .AW(CPU_AW)) i_cpu_cache (
        .clk     (clk),
        .rst     (rst),
        .addr    (cpu_addr),
        .addr_ok (cpu_addr_ok),
        .miss    (miss[0]),
        .fill    (fill[0]),
        .dout    (cpu_dout),
        .data_ok (cpu_data_ok)
    );

    rom_req_cache #(.DW(16), .AW(GFX_AW)) i_gfx_cache (
        .clk     (clk),
        .rst     (rst),
        .addr    (gfx_addr),
        .addr_ok (gfx_addr_ok),
        .miss    (miss[1]),
        .fill    (fill[1]),
        .dout    (gfx_dout),
        .data_ok (gfx_data_ok)
    );

    rom_sdram_arbiter i_arbiter (
        .clk        (clk),
        .rst        (rst),
        .miss       (miss),
        .fill       (fill),
        .port_ofs   (port_ofs),
        .fetch_done (fetch_done),
        .sdram_req  (sdram_req),
        .sdram_rsp  (sdram_rsp)
    );

    rom_cfg_regs i_cfg_regs (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .port_ofs   (port_ofs),
        .fetch_done (fetch_done)
    );

endmodule

// ==== dv/rom_subsys_tb.sv ====
`timescale 1ns/1ps
`include "rom_macros.svh"

// testbench for the rom access layer, sdram modeled as a memory with random latency
module rom_subsys_tb;

    localparam int NROWS = 12;
    localparam logic [`ROM_SDRAM_AW-1:0] OFS0 = 'h100;  // cpu base, in sdram words
    localparam logic [`ROM_SDRAM_AW-1:0] OFS1 = 'h2000; // gfx base

    logic                     clk = 1'b0;
    logic                     rst;
    logic [17:0]              cpu_addr;
    logic                     cpu_addr_ok;
    logic [7:0]               cpu_dout;
    logic                     cpu_data_ok;
    logic [16:0]              gfx_addr;
    logic                     gfx_addr_ok;
    logic [15:0]              gfx_dout;
    logic                     gfx_data_ok;
    rom_pkg::sdram_rd_req_t   sdram_req;
    rom_pkg::sdram_rd_req_t   req_q;           // request as it stood before the last rising edge
    rom_pkg::rom_fill_t       sdram_rsp = '0;
    axil_pkg::axil_req_t      axil_req;
    axil_pkg::axil_rsp_t      axil_rsp;

    logic [31:0]              lfsr = 32'hcf1ac725;
    logic                     rst_q = 1'b1;
    logic                     rd_busy = 1'b0;  // model holds one read
    logic [`ROM_SDRAM_AW-1:0] rd_addr;
    logic [`ROM_SDRAM_AW-1:0] last_rd_addr;
    int                       rd_wait;
    int                       rd_count = 0;    // reads accepted
    int                       rd_done = 0;     // words returned
    int                       aw_takes = 0;    // write addresses accepted by the slave
    int                       w_takes = 0;     // write data beats accepted
    int                       ar_takes = 0;    // read addresses accepted
    int                       errors = 0;
    int                       tests_run = 0;
    int                       tests_bad = 0;
    int                       test_err0;
    string                    cur_test;
    int                       exp_cnt [2];     // fetch counters as the table predicts them

    string       row_name [NROWS];
    int          row_port [NROWS];  // 0 cpu, 1 gfx, 2 both in the same cycle
    logic [17:0] row_addr [NROWS];  // gfx takes the low 17 bits
    bit          row_fresh [NROWS]; // sdram fetch expected

    rom_subsys_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr    (cpu_addr),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_dout    (cpu_dout),
        .cpu_data_ok (cpu_data_ok),
        .gfx_addr    (gfx_addr),
        .gfx_addr_ok (gfx_addr_ok),
        .gfx_dout    (gfx_dout),
        .gfx_data_ok (gfx_data_ok),
        .sdram_req   (sdram_req),
        .sdram_rsp   (sdram_rsp),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp)
    );

    always #5 clk = ~clk; // 10 ns period

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr); // one step per bit
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // sdram contents: low half is the word address, high half its inverse
    function automatic logic [31:0] mem_word(input logic [`ROM_SDRAM_AW-1:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    function automatic logic [7:0] exp_byte(input logic [17:0] a);
        logic [31:0] w;
        w = mem_word(`ROM_SDRAM_AW'(a >> 2) + OFS0);
        return w[a[1:0]*8 +: 8]; // byte lane from the low address bits
    endfunction

    function automatic logic [15:0] exp_half(input logic [16:0] a);
        logic [31:0] w;
        w = mem_word(`ROM_SDRAM_AW'(a >> 1) + OFS1);
        return a[0] ? w[31:16] : w[15:0];
    endfunction

    always @(posedge clk) begin
        req_q <= sdram_req;
        rst_q <= rst;
    end

    // axi accepts as the slave sees them at each rising edge
    always @(posedge clk) begin
        if (axil_req.awvalid && axil_rsp.awready) begin
            aw_takes++;
        end
        if (axil_req.wvalid && axil_rsp.wready) begin
            w_takes++;
        end
        if (axil_req.arvalid && axil_rsp.arready) begin
            ar_takes++;
        end
    end

    // sdram model: takes one read, answers 1 to 8 cycles later
    always @(negedge clk) begin
        if (rst_q) begin
            sdram_rsp = '0;
            rd_busy = 1'b0;
        end else if (sdram_rsp.valid) begin
            sdram_rsp.valid = 1'b0; // consumed at the last rising edge
        end else if (!rd_busy && req_q.valid) begin
            rd_busy = 1'b1;
            rd_addr = req_q.addr;
            last_rd_addr = req_q.addr;
            rd_wait = 1 + rand_bits(3);
            rd_count++;
        end else if (rd_busy) begin
            rd_wait--;
            if (rd_wait == 0) begin
                sdram_rsp.valid = 1'b1;
                sdram_rsp.data.bytes = mem_word(rd_addr);
                rd_busy = 1'b0;
                rd_done++;
            end
        end
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_err0) begin
            tests_bad++;
        end
        $display("%s: %s", cur_test, (errors == test_err0) ? "ok" : "mismatch");
    endtask

    task automatic axi_write(input logic [`ROM_AXI_AW-1:0] a, input logic [31:0] d,
                             output logic [1:0] resp);
        int aw0;
        int w0;
        aw0 = aw_takes;
        w0 = w_takes;
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr = a;
        axil_req.wvalid = 1'b1;
        axil_req.wdata = d;
        axil_req.wstrb = 4'hf;
        axil_req.bready = 1'b1;
        @(negedge clk);
        while (!axil_rsp.bvalid) begin
            @(negedge clk);
        end
        resp = axil_rsp.bresp;
        axil_req.awvalid = 1'b0; // bvalid already blocks a second take
        axil_req.wvalid = 1'b0;
        check("awready accepts", 32'd1, aw_takes - aw0); // aw and w taken once, together
        check("wready accepts", 32'd1, w_takes - w0);
    endtask

    task automatic axi_read(input logic [`ROM_AXI_AW-1:0] a, output logic [31:0] d,
                            output logic [1:0] resp);
        int ar0;
        ar0 = ar_takes;
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr = a;
        axil_req.rready = 1'b1;
        @(negedge clk);
        while (!axil_rsp.rvalid) begin
            @(negedge clk);
        end
        d = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        axil_req.arvalid = 1'b0;
        check("arready accepts", 32'd1, ar_takes - ar0); // arready drops while rvalid waits
    endtask

    task automatic check_reg(input logic [`ROM_AXI_AW-1:0] a, input logic [31:0] exp,
                             input string what);
        logic [31:0] d;
        logic [1:0]  resp;
        axi_read(a, d, resp);
        check({what, " rresp"}, axil_pkg::RESP_OKAY, resp);
        check(what, exp, d);
    endtask

    task automatic set_row(input int i, input string n, input int p, input logic [17:0] a,
                           input bit f);
        row_name[i] = n;
        row_port[i] = p;
        row_addr[i] = a;
        row_fresh[i] = f;
    endtask

    // word 0 is left to the reset prefill and never used here
    task automatic load_table();
        set_row(0, "cpu_lane0", 0, 18'h00010, 1'b1);
        set_row(1, "cpu_lane1", 0, 18'h00011, 1'b0);
        set_row(2, "cpu_lane2", 0, 18'h00012, 1'b0);
        set_row(3, "cpu_lane3", 0, 18'h00013, 1'b0);
        set_row(4, "gfx_a_lo", 1, 18'h00040, 1'b1);       // goes to entry 0
        set_row(5, "gfx_a_hi", 1, 18'h00041, 1'b0);
        set_row(6, "gfx_b", 1, 18'h00080, 1'b1);          // entry 1
        set_row(7, "gfx_c_evicts_a", 1, 18'h000c1, 1'b1); // victim back on entry 0
        set_row(8, "gfx_b_kept", 1, 18'h00081, 1'b0);
        set_row(9, "gfx_a_refetch", 1, 18'h00040, 1'b1);
        set_row(10, "both_miss", 2, 18'h00400, 1'b1);
        set_row(11, "cpu_hit_after", 0, 18'h00402, 1'b0);
    endtask

    task automatic run_row(input int r);
        int          p;
        int          reads0;
        bit          cpu_wait;
        bit          gfx_wait;
        logic [7:0]  cpu_got;
        logic [15:0] gfx_got;
        logic [17:0] a;
        p = row_port[r];
        a = row_addr[r];
        begin_test(row_name[r]);
        cpu_wait = (p != 1);
        gfx_wait = (p != 0);
        reads0 = rd_count;
        @(negedge clk);
        if (cpu_wait) begin
            cpu_addr = a;
            cpu_addr_ok = 1'b1;
        end
        if (gfx_wait) begin
            gfx_addr = a[16:0];
            gfx_addr_ok = 1'b1;
        end
        while (cpu_wait || gfx_wait) begin
            @(negedge clk);
            if (cpu_wait && cpu_data_ok) begin
                cpu_got = cpu_dout;
                cpu_addr_ok = 1'b0; // access ends with data_ok
                cpu_wait = 1'b0;
            end
            if (gfx_wait && gfx_data_ok) begin
                gfx_got = gfx_dout;
                gfx_addr_ok = 1'b0;
                gfx_wait = 1'b0;
            end
        end
        check("sdram reads", row_fresh[r] ? ((p == 2) ? 2 : 1) : 0, rd_count - reads0);
        if (p != 1) begin
            check("cpu byte", exp_byte(a), cpu_got);
            exp_cnt[0] += int'(row_fresh[r]);
            check_reg(`ROM_REG_CNT0, exp_cnt[0], "cpu fetch count");
        end
        if (p != 0) begin
            check("gfx half", exp_half(a[16:0]), gfx_got);
            exp_cnt[1] += int'(row_fresh[r]);
            check_reg(`ROM_REG_CNT1, exp_cnt[1], "gfx fetch count");
        end
        // sdram address must carry the port offset
        if (row_fresh[r] && p == 0) begin
            check("sdram addr", `ROM_SDRAM_AW'(a >> 2) + OFS0, last_rd_addr);
        end
        if (row_fresh[r] && p == 1) begin
            check("sdram addr", `ROM_SDRAM_AW'(a[16:0] >> 1) + OFS1, last_rd_addr);
        end
        end_test();
    endtask

    initial begin
        logic [31:0] rd_val;
        logic [1:0]  resp;
        rst = 1'b1;
        cpu_addr = '0;
        cpu_addr_ok = 1'b0;
        gfx_addr = '0;
        gfx_addr_ok = 1'b0;
        axil_req = '0;
        load_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        // each cache fetches once right after reset, before any addr_ok
        while (rd_done < 2) begin
            @(negedge clk);
        end
        @(negedge clk);
        exp_cnt[0] = 1;
        exp_cnt[1] = 1;

        begin_test("axi_offsets");
        axi_write(`ROM_REG_OFS0, 32'(OFS0), resp);
        check("ofs0 bresp", axil_pkg::RESP_OKAY, resp);
        axi_write(`ROM_REG_OFS1, 32'(OFS1), resp);
        check("ofs1 bresp", axil_pkg::RESP_OKAY, resp);
        check_reg(`ROM_REG_OFS0, 32'(OFS0), "ofs0");
        check_reg(`ROM_REG_OFS1, 32'(OFS1), "ofs1");
        check_reg(`ROM_REG_CNT0, exp_cnt[0], "cnt0 after prefill");
        check_reg(`ROM_REG_CNT1, exp_cnt[1], "cnt1 after prefill");
        end_test();

        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end

        begin_test("axi_errors");
        axi_read(8'h10, rd_val, resp); // past the last register
        check("unmapped rresp", axil_pkg::RESP_SLVERR, resp);
        check("unmapped rdata", 32'h0, rd_val);
        axi_write(`ROM_REG_CNT0, 32'hdead_beef, resp);
        check("cnt0 bresp", axil_pkg::RESP_OKAY, resp);
        check_reg(`ROM_REG_CNT0, exp_cnt[0], "cnt0 after write");
        end_test();

        $display("%0d tests, %0d with mismatches, %0d errors", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // each row needs well under 40 cycles
    initial begin
        repeat (NROWS * 40 + 2000) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles", NROWS * 40 + 2000);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== rom_subsys_top.f ====
+incdir+include
hw/rom_pkg.sv
hw/axil_pkg.sv
hw/rom_req_cache.sv
hw/rom_sdram_arbiter.sv
hw/rom_cfg_regs.sv
hw/rom_subsys_top.sv
dv/rom_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rom subsystem testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rom_subsys_tb \
    -f rom_subsys_top.f

out=$(./obj_dir/Vrom_subsys_tb)
echo "$out"

if grep -qF -- '** PASS **' <<< "$out"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
